//--- tb.f
+incdir+test
src/cpuCtrlPkg.sv
src/instrDecoder.sv
src/stateSequencer.sv
src/controlOutputs.sv
src/controlUnit.sv
test/controlUnitTb.sv

//--- Bender.yml
package:
  name: control_unit

sources:
  - files:
      - src/cpuCtrlPkg.sv
      - src/instrDecoder.sv
      - src/stateSequencer.sv
      - src/controlOutputs.sv
      - src/controlUnit.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/controlUnitTb.sv

//--- test/ctrlTbTasks.svh
`ifndef CTRL_TB_TASKS_SVH
`define CTRL_TB_TASKS_SVH

function automatic logic [31:0] lfsrNext(logic [31:0] s);
	logic [31:0] n;
	n = s >> 1;
	if (s[0]) begin
		n = n ^ 32'hD0000001; // x^32 + x^31 + x^29 + x + 1
	end
	return n;
endfunction

function automatic logic [31:0] randBits(int count);
	logic [31:0] value;
	value = '0;
	for (int i = 0; i < count; i++) begin
		lfsrState = lfsrNext(lfsrState);
		value     = {value[30:0], lfsrState[0]};
	end
	return value;
endfunction

// Random register numbers and immediates around fixed opcode and funct3
function automatic logic [31:0] randomInstr(logic [6:0] opcode, logic [2:0] funct3);
	logic [31:0] word;
	word         = randBits(32);
	word[14:12]  = funct3;
	word[6:0]    = opcode;
	return word;
endfunction

function automatic logic [31:0] withTop7(logic [31:0] word, logic [6:0] funct7);
	logic [31:0] result;
	result        = word;
	result[31:25] = funct7;
	return result;
endfunction

function automatic cpuCtrlPkg::ctrlWord_t idleWord();
	cpuCtrlPkg::ctrlWord_t w;
	w              = '0;
	w.aluOperation = cpuCtrlPkg::aluLoad;
	w.loadType     = cpuCtrlPkg::ldNone;
	return w;
endfunction

function automatic cpuCtrlPkg::ctrlWord_t fetchWord();
	cpuCtrlPkg::ctrlWord_t w;
	w              = idleWord();
	w.selMuxB      = 3'd1;
	w.selMuxMem    = 3'd1;
	w.pcWrite      = 1'b1;
	w.memRead      = 1'b1;
	w.loadIr       = 1'b1;
	w.aluOperation = cpuCtrlPkg::aluAdd;
	return w;
endfunction

task automatic compareValue(string sigName, logic [63:0] expected, logic [63:0] actual);
	checkCount++;
	if (actual !== expected) begin
		errorCount++;
		$display("FAILED at %0t ns in %s: %s expected %0h, got %0h",
			$time, currentTest, sigName, expected, actual);
	end
endtask

task automatic nextCycle();
	@(negedge clk);
	#1;
endtask

task automatic startInstr(string name, logic [31:0] word, logic zero, logic less);
	currentTest = name;
	@(negedge clk);
	instr   = word;
	aluZero = zero;
	aluLess = less;
	#1;
	compareValue("ctrl (fetch)", fetchWord(), ctrl);
endtask

task automatic checkDecode();
	nextCycle();
	compareValue("ctrl.selMuxB", 3'd3, ctrl.selMuxB);
	compareValue("ctrl.loadRegA", 1'b1, ctrl.loadRegA);
	compareValue("ctrl.loadRegB", 1'b1, ctrl.loadRegB);
	compareValue("ctrl.loadRegAluOut", 1'b1, ctrl.loadRegAluOut);
	compareValue("ctrl.memRead", 1'b1, ctrl.memRead);
	compareValue("ctrl.loadIr", 1'b0, ctrl.loadIr);
	compareValue("ctrl.regWrite", 1'b0, ctrl.regWrite);
endtask

task automatic returnToFetch();
	@(posedge clk);
	#1;
	compareValue("ctrl (fetch again)", fetchWord(), ctrl);
endtask

task automatic finishInstr();
	nextCycle();
	compareValue("ctrl (idle)", idleWord(), ctrl);
	returnToFetch();
endtask

task automatic resetTest();
	repeat (3) begin
		@(posedge clk);
		#1;
		compareValue("ctrl (in reset)", idleWord(), ctrl);
	end
	@(negedge clk);
	rst = 1'b0;
	#1;
	compareValue("ctrl (after reset)", idleWord(), ctrl);
	returnToFetch();
endtask

task automatic aluTest(string name, logic [31:0] word, cpuCtrlPkg::aluOp_e expOp,
		logic [2:0] expSelB, bit isSlt);
	startInstr(name, word, 1'(randBits(1)), 1'(randBits(1)));
	checkDecode();
	nextCycle();
	compareValue("ctrl.selMuxB", expSelB, ctrl.selMuxB);
	compareValue("ctrl.aluOperation", expOp, ctrl.aluOperation);
	compareValue("ctrl.selMuxAlu", isSlt, ctrl.selMuxAlu);
	compareValue("ctrl.regWrite", 1'b0, ctrl.regWrite);
	nextCycle();
	compareValue("ctrl.regWrite", 1'b1, ctrl.regWrite);
	finishInstr();
endtask

task automatic loadTest(string name, logic [2:0] funct3, cpuCtrlPkg::loadType_e expType);
	startInstr(name, randomInstr(cpuCtrlPkg::opLoad, funct3), 1'b0, 1'b0);
	checkDecode();
	nextCycle();
	compareValue("ctrl.loadType", expType, ctrl.loadType);
	compareValue("ctrl.loadRegAluOut", 1'b1, ctrl.loadRegAluOut);
	compareValue("ctrl.regWrite", 1'b0, ctrl.regWrite);
	nextCycle();
	compareValue("ctrl.loadRegMemData", 1'b1, ctrl.loadRegMemData);
	compareValue("ctrl.regWrite", 1'b0, ctrl.regWrite);
	nextCycle();
	compareValue("ctrl.regWrite", 1'b1, ctrl.regWrite);
	compareValue("ctrl.selMuxMem", 3'd1, ctrl.selMuxMem);
	finishInstr();
endtask

task automatic storeTest(string name, logic [2:0] funct3);
	startInstr(name, randomInstr(cpuCtrlPkg::opStore, funct3), 1'b0, 1'b0);
	checkDecode();
	compareValue("ctrl.memDataWrite", 1'b0, ctrl.memDataWrite);
	nextCycle();
	compareValue("ctrl.memDataWrite", 1'b0, ctrl.memDataWrite);
	compareValue("ctrl.regWrite", 1'b0, ctrl.regWrite);
	nextCycle();
	compareValue("ctrl.memDataWrite", 1'b1, ctrl.memDataWrite);
	compareValue("ctrl.regWrite", 1'b0, ctrl.regWrite);
	finishInstr();
endtask

task automatic branchTest(string name, logic [2:0] funct3);
	logic zero;
	logic less;
	logic taken;
	zero = 1'(randBits(1));
	less = 1'(randBits(1));
	case (funct3)
		3'b000:  taken = zero;
		3'b001:  taken = !zero;
		3'b101:  taken = !less;
		default: taken = less;
	endcase
	startInstr(name, randomInstr(cpuCtrlPkg::opBranch, funct3), zero, less);
	checkDecode();
	nextCycle();
	compareValue("ctrl.pcWrite", taken, ctrl.pcWrite);
	compareValue("ctrl.pcWriteCond", taken, ctrl.pcWriteCond);
	compareValue("ctrl.selMuxPc", taken, ctrl.selMuxPc);
	compareValue("ctrl.selMuxA", 3'd1, ctrl.selMuxA);
	compareValue("ctrl.aluOperation",
		(funct3 == 3'b100) ? cpuCtrlPkg::aluNone : cpuCtrlPkg::aluSub, ctrl.aluOperation);
	finishInstr();
endtask

task automatic shiftTest(string name, logic [2:0] funct3, logic [5:0] funct6,
		cpuCtrlPkg::shiftKind_e expShift);
	logic [31:0] word;
	word        = randomInstr(cpuCtrlPkg::opImm, funct3);
	word[31:26] = funct6; // shamt stays random
	startInstr(name, word, 1'b0, 1'b0);
	checkDecode();
	nextCycle();
	compareValue("ctrl.shift", expShift, ctrl.shift);
	compareValue("ctrl.selMuxMem", 3'd3, ctrl.selMuxMem);
	compareValue("ctrl.regWrite", 1'b1, ctrl.regWrite);
	finishInstr();
endtask

task automatic luiTest();
	startInstr("lui", randomInstr(cpuCtrlPkg::opLui, 3'(randBits(3))), 1'b0, 1'b0);
	checkDecode();
	nextCycle();
	compareValue("ctrl.selMuxMem", 3'd2, ctrl.selMuxMem);
	compareValue("ctrl.regWrite", 1'b1, ctrl.regWrite);
	finishInstr();
endtask

// Decode goes straight back to fetch
task automatic unknownTest(string name, logic [6:0] opcode);
	startInstr(name, randomInstr(opcode, 3'(randBits(3))), 1'b0, 1'b0);
	checkDecode();
	returnToFetch();
endtask

`endif

//--- test/controlUnitTb.sv
module controlUnitTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int clkPeriod = 10;
	// Edges spent by the whole sequence in the initial block below
	localparam int testCycles = 5 + 2 * 6 * 5 + 7 * 6 + 4 * 5 + 4 * 4 * 4 + 3 * 4 + 4 + 2 * 2;

	logic                  clk;
	logic                  rst;
	logic [31:0]           instr;
	logic                  aluZero;
	logic                  aluLess;
	cpuCtrlPkg::ctrlWord_t ctrl;

	int          errorCount;
	int          checkCount;
	string       currentTest;
	logic [31:0] lfsrState;

	controlUnit u_dut (
		.clk     (clk),
		.rst     (rst),
		.instr   (instr),
		.aluZero (aluZero),
		.aluLess (aluLess),
		.ctrl    (ctrl)
	);

	always #(clkPeriod / 2) clk = ~clk;

	`include "ctrlTbTasks.svh"

	// Watchdog
	initial begin
		#(testCycles * 4 * clkPeriod + 200);
		$display("Timeout: the test sequence did not finish within %0d ns",
			testCycles * 4 * clkPeriod + 200);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		clk         = 1'b0;
		rst         = 1'b1;
		instr       = '0;
		aluZero     = 1'b0;
		aluLess     = 1'b0;
		errorCount  = 0;
		checkCount  = 0;
		lfsrState   = 32'd89851;
		currentTest = "reset";

		resetTest();

		for (int rep = 0; rep < 2; rep++) begin
			aluTest("add", withTop7(randomInstr(cpuCtrlPkg::opReg, 3'b000), 7'b0000000),
				cpuCtrlPkg::aluAdd, 3'd0, 1'b0);
			aluTest("sub", withTop7(randomInstr(cpuCtrlPkg::opReg, 3'b000), 7'b0100000),
				cpuCtrlPkg::aluSub, 3'd0, 1'b0);
			aluTest("and", withTop7(randomInstr(cpuCtrlPkg::opReg, 3'b111), 7'b0000000),
				cpuCtrlPkg::aluAnd, 3'd0, 1'b0);
			aluTest("slt", withTop7(randomInstr(cpuCtrlPkg::opReg, 3'b010), 7'b0000000),
				cpuCtrlPkg::aluLoad, 3'd0, 1'b1);
			aluTest("addi", randomInstr(cpuCtrlPkg::opImm, 3'b000),
				cpuCtrlPkg::aluAdd, 3'd2, 1'b0);
			aluTest("slti", randomInstr(cpuCtrlPkg::opImm, 3'b010),
				cpuCtrlPkg::aluLoad, 3'd2, 1'b1);
		end

		loadTest("lb", 3'b000, cpuCtrlPkg::ldByte);
		loadTest("lh", 3'b001, cpuCtrlPkg::ldHalf);
		loadTest("lw", 3'b010, cpuCtrlPkg::ldWord);
		loadTest("ld", 3'b011, cpuCtrlPkg::ldDouble);
		loadTest("lbu", 3'b100, cpuCtrlPkg::ldNone);
		loadTest("lhu", 3'b101, cpuCtrlPkg::ldNone);
		loadTest("lwu", 3'b110, cpuCtrlPkg::ldNone);

		storeTest("sb", 3'b000);
		storeTest("sh", 3'b001);
		storeTest("sw", 3'b010);
		storeTest("sd", 3'b011);

		for (int rep = 0; rep < 4; rep++) begin
			branchTest("beq", 3'b000);
			branchTest("bne", 3'b001);
			branchTest("bge", 3'b101);
			branchTest("blt", 3'b100);
		end

		shiftTest("slli", 3'b001, 6'b000000, cpuCtrlPkg::shLeft);
		shiftTest("srli", 3'b101, 6'b000000, cpuCtrlPkg::shRightLogic);
		shiftTest("srai", 3'b101, 6'b010000, cpuCtrlPkg::shRightArith);
		luiTest();
		unknownTest("opcode zero", 7'b0000000);
		unknownTest("jal", 7'b1101111);

		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- src/controlUnit.sv
module controlUnit (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [31:0]           instr,
	input  logic                  aluZero,
	input  logic                  aluLess,
	output cpuCtrlPkg::ctrlWord_t ctrl
);

	cpuCtrlPkg::decodedInstr_t decoded;
	cpuCtrlPkg::ctrlState_e    state;

	instrDecoder u_instrDecoder (
		.instr   (instr),
		.decoded (decoded)
	);

	stateSequencer u_stateSequencer (
		.clk     (clk),
		.rst     (rst),
		.decoded (decoded),
		.state   (state)
	);

	controlOutputs u_controlOutputs (
		.state   (state),
		.decoded (decoded),
		.aluZero (aluZero),
		.aluLess (aluLess),
		.ctrl    (ctrl)
	);

endmodule

//--- src/controlOutputs.sv
module controlOutputs (
	input  cpuCtrlPkg::ctrlState_e    state,
	input  cpuCtrlPkg::decodedInstr_t decoded,
	input  logic                      aluZero,
	input  logic                      aluLess,
	output cpuCtrlPkg::ctrlWord_t     ctrl
);

	logic branchTaken;
	logic immOperand;

	// Second ALU operand comes from the immediate for addi and slti
	assign immOperand = decoded.opClass inside {cpuCtrlPkg::clsAluImm, cpuCtrlPkg::clsSltImm};

	always_comb begin
		case (decoded.branchKind)
			cpuCtrlPkg::brEq: branchTaken = aluZero;
			cpuCtrlPkg::brNe: branchTaken = !aluZero;
			cpuCtrlPkg::brGe: branchTaken = !aluLess;
			default:          branchTaken = aluLess; // blt
		endcase
	end

	always_comb begin
		ctrl              = '0;
		ctrl.aluOperation = cpuCtrlPkg::aluLoad;
		ctrl.shift        = cpuCtrlPkg::shLeft;
		ctrl.loadType     = cpuCtrlPkg::ldNone;
		case (state)
			cpuCtrlPkg::stFetch: begin
				ctrl.selMuxB      = 3'd1; // PC + 4
				ctrl.selMuxMem    = 3'd1;
				ctrl.pcWrite      = 1'b1;
				ctrl.memRead      = 1'b1;
				ctrl.loadIr       = 1'b1;
				ctrl.aluOperation = cpuCtrlPkg::aluAdd;
			end
			cpuCtrlPkg::stDecode: begin
				ctrl.selMuxB       = 3'd3; // Branch target ahead of time
				ctrl.loadRegA      = 1'b1;
				ctrl.loadRegB      = 1'b1;
				ctrl.loadRegAluOut = 1'b1;
				ctrl.memRead       = 1'b1;
				ctrl.aluOperation  = cpuCtrlPkg::aluAdd;
			end
			cpuCtrlPkg::stAluExec: begin
				ctrl.selMuxA       = 3'd1;
				ctrl.selMuxB       = immOperand ? 3'd2 : 3'd0;
				ctrl.loadRegAluOut = 1'b1;
				ctrl.aluOperation  = decoded.aluOp;
			end
			cpuCtrlPkg::stSltExec: begin
				ctrl.selMuxA   = 3'd1;
				ctrl.selMuxB   = immOperand ? 3'd2 : 3'd0;
				ctrl.selMuxAlu = 1'b1; // Less flag to write-back path
			end
			cpuCtrlPkg::stWriteBack: ctrl.regWrite = 1'b1;
			cpuCtrlPkg::stShift: begin
				ctrl.selMuxMem = 3'd3;
				ctrl.regWrite  = 1'b1;
				ctrl.shift     = decoded.shiftKind;
			end
			cpuCtrlPkg::stMemAddr: begin
				ctrl.selMuxA       = 3'd1;
				ctrl.selMuxB       = 3'd2;
				ctrl.selMuxMem     = 3'd1;
				ctrl.loadRegAluOut = 1'b1;
				ctrl.aluOperation  = cpuCtrlPkg::aluAdd;
				ctrl.loadType      = decoded.loadType;
			end
			cpuCtrlPkg::stLoadData: ctrl.loadRegMemData = 1'b1;
			cpuCtrlPkg::stLoadWrite: begin
				ctrl.selMuxMem = 3'd1;
				ctrl.regWrite  = 1'b1;
			end
			cpuCtrlPkg::stStoreWrite: ctrl.memDataWrite = 1'b1;
			cpuCtrlPkg::stBranch: begin
				ctrl.selMuxA      = 3'd1;
				ctrl.selMuxMem    = 3'd1;
				ctrl.aluOperation = decoded.aluOp;
				ctrl.pcWrite      = branchTaken;
				ctrl.pcWriteCond  = branchTaken;
				ctrl.selMuxPc     = branchTaken; // Take target from ALU out
			end
			cpuCtrlPkg::stLuiWrite: begin
				ctrl.selMuxB   = 3'd2;
				ctrl.selMuxMem = 3'd2; // Upper immediate
				ctrl.regWrite  = 1'b1;
			end
			default: ;
		endcase
	end

	// Register file and data memory are never written in the same cycle
	always_comb begin
		assert #0 (!(ctrl.regWrite && ctrl.memDataWrite))
			else $error("regWrite and memDataWrite both high");
	end

endmodule

//--- src/stateSequencer.sv
module stateSequencer (
	input  logic                      clk,
	input  logic                      rst,
	input  cpuCtrlPkg::decodedInstr_t decoded,
	output cpuCtrlPkg::ctrlState_e    state
);

	cpuCtrlPkg::ctrlState_e nextState;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= cpuCtrlPkg::stIdle;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = cpuCtrlPkg::stIdle;
		case (state)
			cpuCtrlPkg::stIdle:   nextState = cpuCtrlPkg::stFetch;
			cpuCtrlPkg::stFetch:  nextState = cpuCtrlPkg::stDecode;
			cpuCtrlPkg::stDecode: begin
				case (decoded.opClass)
					cpuCtrlPkg::clsAluReg,
					cpuCtrlPkg::clsAluImm: nextState = cpuCtrlPkg::stAluExec;
					cpuCtrlPkg::clsSltReg,
					cpuCtrlPkg::clsSltImm: nextState = cpuCtrlPkg::stSltExec;
					cpuCtrlPkg::clsShift:  nextState = cpuCtrlPkg::stShift;
					cpuCtrlPkg::clsLoad,
					cpuCtrlPkg::clsStore:  nextState = cpuCtrlPkg::stMemAddr;
					cpuCtrlPkg::clsBranch: nextState = cpuCtrlPkg::stBranch;
					cpuCtrlPkg::clsLui:    nextState = cpuCtrlPkg::stLuiWrite;
					default:               nextState = cpuCtrlPkg::stFetch; // Unknown opcode
				endcase
			end
			cpuCtrlPkg::stAluExec,
			cpuCtrlPkg::stSltExec: nextState = cpuCtrlPkg::stWriteBack;
			cpuCtrlPkg::stMemAddr: begin
				// Instruction register still holds the word here
				if (decoded.opClass == cpuCtrlPkg::clsLoad) begin
					nextState = cpuCtrlPkg::stLoadData;
				end else begin
					nextState = cpuCtrlPkg::stStoreWrite;
				end
			end
			cpuCtrlPkg::stLoadData: nextState = cpuCtrlPkg::stLoadWrite;
			// Every finished instruction rests one cycle in idle
			cpuCtrlPkg::stWriteBack,
			cpuCtrlPkg::stShift,
			cpuCtrlPkg::stLoadWrite,
			cpuCtrlPkg::stStoreWrite,
			cpuCtrlPkg::stBranch,
			cpuCtrlPkg::stLuiWrite: nextState = cpuCtrlPkg::stIdle;
			default: nextState = cpuCtrlPkg::stIdle;
		endcase
	end

	fetchThenDecode: assert property (
		@(posedge clk) disable iff (rst)
		state == cpuCtrlPkg::stFetch |=> state == cpuCtrlPkg::stDecode
	) else $error("fetch not followed by decode");

endmodule

//--- src/instrDecoder.sv
module instrDecoder (
	input  logic [31:0]               instr,
	output cpuCtrlPkg::decodedInstr_t decoded
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [5:0] shiftFunct; // RV64 shifts use a 6-bit shamt

	assign opcode     = instr[6:0];
	assign funct3     = instr[14:12];
	assign funct7     = instr[31:25];
	assign shiftFunct = instr[31:26];

	always_comb begin
		decoded.opClass    = cpuCtrlPkg::clsUnknown;
		decoded.aluOp      = cpuCtrlPkg::aluLoad;
		decoded.shiftKind  = cpuCtrlPkg::shLeft;
		decoded.branchKind = cpuCtrlPkg::brEq;
		decoded.loadType   = cpuCtrlPkg::ldNone;
		case (opcode)
			cpuCtrlPkg::opReg: begin
				if (funct7 == 7'b0000000) begin
					case (funct3)
						3'b000: begin
							decoded.opClass = cpuCtrlPkg::clsAluReg;
							decoded.aluOp   = cpuCtrlPkg::aluAdd;
						end
						3'b111: begin
							decoded.opClass = cpuCtrlPkg::clsAluReg;
							decoded.aluOp   = cpuCtrlPkg::aluAnd;
						end
						3'b010: decoded.opClass = cpuCtrlPkg::clsSltReg;
						default: ;
					endcase
				end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin // sub
					decoded.opClass = cpuCtrlPkg::clsAluReg;
					decoded.aluOp   = cpuCtrlPkg::aluSub;
				end
			end
			cpuCtrlPkg::opImm: begin
				case (funct3)
					3'b000: begin // addi
						decoded.opClass = cpuCtrlPkg::clsAluImm;
						decoded.aluOp   = cpuCtrlPkg::aluAdd;
					end
					3'b010: decoded.opClass = cpuCtrlPkg::clsSltImm;
					3'b001: begin
						if (shiftFunct == 6'b000000) begin
							decoded.opClass = cpuCtrlPkg::clsShift;
						end
					end
					3'b101: begin
						if (shiftFunct == 6'b000000) begin
							decoded.opClass   = cpuCtrlPkg::clsShift;
							decoded.shiftKind = cpuCtrlPkg::shRightLogic;
						end else if (shiftFunct == 6'b010000) begin
							decoded.opClass   = cpuCtrlPkg::clsShift;
							decoded.shiftKind = cpuCtrlPkg::shRightArith;
						end
					end
					default: ;
				endcase
			end
			cpuCtrlPkg::opLoad: begin
				if (funct3 != 3'b111) begin
					decoded.opClass = cpuCtrlPkg::clsLoad;
					decoded.aluOp   = cpuCtrlPkg::aluAdd;
				end
				case (funct3)
					3'b000:  decoded.loadType = cpuCtrlPkg::ldByte;
					3'b001:  decoded.loadType = cpuCtrlPkg::ldHalf;
					3'b010:  decoded.loadType = cpuCtrlPkg::ldWord;
					3'b011:  decoded.loadType = cpuCtrlPkg::ldDouble;
					default: decoded.loadType = cpuCtrlPkg::ldNone; // lbu, lhu, lwu
				endcase
			end
			cpuCtrlPkg::opStore: begin
				// sb, sh, sw, sd
				if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b011}) begin
					decoded.opClass = cpuCtrlPkg::clsStore;
					decoded.aluOp   = cpuCtrlPkg::aluAdd;
				end
			end
			cpuCtrlPkg::opBranch: begin
				decoded.opClass = cpuCtrlPkg::clsBranch;
				decoded.aluOp   = cpuCtrlPkg::aluSub;
				case (funct3)
					3'b000: decoded.branchKind = cpuCtrlPkg::brEq;
					3'b001: decoded.branchKind = cpuCtrlPkg::brNe;
					3'b101: decoded.branchKind = cpuCtrlPkg::brGe;
					3'b100: begin
						decoded.branchKind = cpuCtrlPkg::brLt;
						decoded.aluOp      = cpuCtrlPkg::aluNone;
					end
					default: decoded.opClass = cpuCtrlPkg::clsUnknown;
				endcase
			end
			cpuCtrlPkg::opLui: decoded.opClass = cpuCtrlPkg::clsLui;
			default: ;
		endcase
	end

	// A known word must never leave X on the decoded fields
	always_comb begin
		if (!$isunknown(instr)) begin
			assert #0 (!$isunknown(decoded))
				else $error("decoded fields unknown for instr %h", instr);
		end
	end

endmodule

//--- src/cpuCtrlPkg.sv
package cpuCtrlPkg;

	// Major opcodes handled by this core
	typedef enum logic [6:0] {
		opLoad   = 7'b0000011,
		opImm    = 7'b0010011,
		opStore  = 7'b0100011,
		opReg    = 7'b0110011,
		opLui    = 7'b0110111,
		opBranch = 7'b1100011
	} opcode_e;

	// What the sequencer needs to pick a path
	typedef enum logic [3:0] {
		clsAluReg,
		clsAluImm,
		clsSltReg,
		clsSltImm,
		clsShift,
		clsLoad,
		clsStore,
		clsBranch,
		clsLui,
		clsUnknown
	} opClass_e;

	typedef enum logic [2:0] {
		aluLoad = 3'd0, // Pass through
		aluAdd  = 3'd1,
		aluSub  = 3'd2,
		aluAnd  = 3'd3,
		aluNone = 3'd7  // Compare only, used by blt
	} aluOp_e;

	typedef enum logic [1:0] {
		shLeft       = 2'd0,
		shRightLogic = 2'd1,
		shRightArith = 2'd2
	} shiftKind_e;

	typedef enum logic [1:0] {
		brEq,
		brNe,
		brGe,
		brLt
	} branchKind_e;

	// Unsigned loads carry no size code
	typedef enum logic [2:0] {
		ldNone   = 3'd0,
		ldDouble = 3'd1,
		ldWord   = 3'd2,
		ldHalf   = 3'd3,
		ldByte   = 3'd4
	} loadType_e;

	typedef enum logic [3:0] {
		stIdle,
		stFetch,
		stDecode,
		stAluExec,
		stSltExec,
		stWriteBack,
		stShift,
		stMemAddr,
		stLoadData,
		stLoadWrite,
		stStoreWrite,
		stBranch,
		stLuiWrite
	} ctrlState_e;

	typedef struct packed {
		opClass_e    opClass;
		aluOp_e      aluOp;
		shiftKind_e  shiftKind;
		branchKind_e branchKind;
		loadType_e   loadType;
	} decodedInstr_t;

	typedef struct packed {
		logic       selMuxPc;
		logic       selMuxAlu;
		logic [2:0] selMuxA;
		logic [2:0] selMuxB;
		logic [2:0] selMuxMem;
		aluOp_e     aluOperation;
		shiftKind_e shift;
		loadType_e  loadType;
		logic       pcWrite;
		logic       pcWriteCond;
		logic       loadIr;
		logic       memRead;
		logic       regWrite;
		logic       loadRegA;
		logic       loadRegB;
		logic       loadRegAluOut;
		logic       loadRegMemData;
		logic       memDataWrite;
	} ctrlWord_t;

endpackage
